//--- cfg_slave_pkg.sv
//--------------------
// shared widths, encodings and channel structs for the AXI config slave
// referenced by scoped names from every RTL file
//--------------------
package cfg_slave_pkg;

   localparam int ID_W     = 4;
   localparam int NUM_IDS  = 16;   // one burst slot per ID
   localparam int ADDR_W   = 4;    // word address, wraps in the regfile
   localparam int NUM_REGS = 16;
   localparam int DATA_W   = 32;
   localparam int STRB_W   = 4;
   localparam int LEN_W    = 4;    // beats = len + 1
   localparam int CNT_W    = 5;    // beats remaining, up to 16

   localparam int REG_CTRL = 0;    // bit 0 is the core reset
   localparam int REG_PC   = 1;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_BURST,
      WR_RESP
   } wr_state_e;

   typedef enum logic {
      RD_IDLE,
      RD_BURST
   } rd_state_e;

   //--------------------
   // channel payloads
   //--------------------
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
   } addr_req_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } w_beat_t;

   typedef struct packed {
      logic [ID_W-1:0] id;
      axi_resp_e       resp;
   } b_resp_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] data;
      axi_resp_e         resp;
      logic              last;
   } r_beat_t;

   // what a burst slot shows the engines
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [CNT_W-1:0]  remaining;
   } slot_state_t;

endpackage

//--- addr_accept.sv
//--------------------
// address channel acceptor, one per aw and ar
// loads the burst slot of the request ID one cycle after the handshake
//--------------------
module addr_accept (
   input  logic                                                  clk,
   input  logic                                                  reset_n,
   input  cfg_slave_pkg::addr_req_t                              req,
   input  logic                                                  req_valid,
   output logic                                                  req_ready,
   input  cfg_slave_pkg::slot_state_t [cfg_slave_pkg::NUM_IDS-1:0] slots,
   output logic [cfg_slave_pkg::NUM_IDS-1:0]                     load,
   output cfg_slave_pkg::addr_req_t                              load_req
);

   logic [cfg_slave_pkg::NUM_IDS-1:0] busy;
   logic                              fire;

   always_comb begin
      for (int i = 0; i < cfg_slave_pkg::NUM_IDS; i++) begin
         busy[i] = slots[i].valid;
      end
   end

   assign fire = req_valid && req_ready;

   // ready looks one cycle ahead, so skip the cycle after a handshake and the load cycle
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         req_ready <= 1'b0;
         load      <= '0;
      end else begin
         req_ready <= req_valid && !busy[req.id] && !fire && (load == '0);
         load      <= fire ? (cfg_slave_pkg::NUM_IDS'(1) << req.id) : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) load_req <= req;  // payload only
   end

   // a busy slot must never be reloaded
   a_no_load_busy: assert property (@(posedge clk) disable iff (!reset_n)
      (load & busy) == '0);

endmodule

//--- burst_slot.sv
//--------------------
// one pending burst for a single ID
// loaded by addr_accept, stepped and retired by an engine
//--------------------
module burst_slot (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       load,
   input  logic                       advance,
   input  logic                       clear,
   input  cfg_slave_pkg::addr_req_t   load_req,
   output cfg_slave_pkg::slot_state_t state
);

   //--------------------
   // valid flag
   //--------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state.valid <= 1'b0;
      end else if (clear) begin
         state.valid <= 1'b0;
      end else if (load) begin
         state.valid <= 1'b1;
      end
   end

   //--------------------
   // address and beat count
   //--------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state.addr      <= '0;
         state.remaining <= '0;
      end else if (load) begin
         state.addr      <= load_req.addr;
         state.remaining <= cfg_slave_pkg::CNT_W'(load_req.len) + 1'b1;
      end else if (advance) begin
         state.addr      <= state.addr + 1'b1;       // incr burst, wraps
         state.remaining <= state.remaining - 1'b1;
      end
   end

   a_adv_valid: assert property (@(posedge clk) disable iff (!reset_n)
      advance |-> state.valid);

   // an engine never steps past the captured length
   a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
      advance |-> state.remaining != '0);

endmodule

//--- write_engine.sv
//--------------------
// write data engine
// writes each w beat at its slot address and answers with a b response
//--------------------
module write_engine (
   input  logic                                                  clk,
   input  logic                                                  reset_n,
   input  cfg_slave_pkg::w_beat_t                                w,
   input  logic                                                  w_valid,
   output logic                                                  w_ready,
   output cfg_slave_pkg::b_resp_t                                b,
   output logic                                                  b_valid,
   input  logic                                                  b_ready,
   input  cfg_slave_pkg::slot_state_t [cfg_slave_pkg::NUM_IDS-1:0] slots,
   output logic [cfg_slave_pkg::NUM_IDS-1:0]                     advance,
   output logic [cfg_slave_pkg::NUM_IDS-1:0]                     clear,
   output logic                                                  reg_we,
   output logic [cfg_slave_pkg::ADDR_W-1:0]                      reg_idx,
   output logic [cfg_slave_pkg::DATA_W-1:0]                      reg_wdata,
   output logic [cfg_slave_pkg::STRB_W-1:0]                      reg_strb
);

   cfg_slave_pkg::wr_state_e          state;
   cfg_slave_pkg::slot_state_t        cur;
   logic [cfg_slave_pkg::ID_W-1:0]    burst_id;
   logic                              id_ok;
   logic                              accept;
   logic                              len_done;
   logic                              burst_end;

   assign cur = slots[w.id];

   // no interleaving inside a burst, nothing while a response waits
   assign id_ok = (state == cfg_slave_pkg::WR_IDLE) ||
                  (state == cfg_slave_pkg::WR_BURST && w.id == burst_id);

   assign w_ready   = w_valid && cur.valid && id_ok;
   assign accept    = w_valid && w_ready;
   assign len_done  = (cur.remaining == cfg_slave_pkg::CNT_W'(1));
   assign burst_end = w.last || len_done;   // whichever comes first

   always_comb begin
      advance = '0;
      clear   = '0;
      if (accept) begin
         advance[w.id] = 1'b1;
         clear[w.id]   = burst_end;
      end
   end

   // register write bundle
   assign reg_we    = accept;
   assign reg_idx   = cur.addr;
   assign reg_wdata = w.data;
   assign reg_strb  = w.strb;

   //--------------------
   // burst / response FSM
   //--------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state    <= cfg_slave_pkg::WR_IDLE;
         burst_id <= '0;
      end else begin
         case (state)
            cfg_slave_pkg::WR_IDLE, cfg_slave_pkg::WR_BURST: begin
               if (accept) begin
                  burst_id <= w.id;
                  state    <= burst_end ? cfg_slave_pkg::WR_RESP : cfg_slave_pkg::WR_BURST;
               end
            end
            cfg_slave_pkg::WR_RESP: if (b_ready) state <= cfg_slave_pkg::WR_IDLE;
            default: state <= cfg_slave_pkg::WR_IDLE;
         endcase
      end
   end

   assign b_valid = (state == cfg_slave_pkg::WR_RESP);

   always_ff @(posedge clk) begin
      if (accept && burst_end) begin
         b.id   <= w.id;
         b.resp <= (w.last && len_done) ? cfg_slave_pkg::RESP_OKAY   // both ends agree
                                        : cfg_slave_pkg::RESP_SLVERR;
      end
   end

   a_b_stable: assert property (@(posedge clk) disable iff (!reset_n)
      b_valid && !b_ready |=> b_valid && $stable(b));

endmodule

//--- read_engine.sv
//--------------------
// read data engine
// serves the lowest pending read slot, one word per accepted r beat
//--------------------
module read_engine (
   input  logic                                                  clk,
   input  logic                                                  reset_n,
   output cfg_slave_pkg::r_beat_t                                r,
   output logic                                                  r_valid,
   input  logic                                                  r_ready,
   input  cfg_slave_pkg::slot_state_t [cfg_slave_pkg::NUM_IDS-1:0] slots,
   output logic [cfg_slave_pkg::NUM_IDS-1:0]                     advance,
   output logic [cfg_slave_pkg::NUM_IDS-1:0]                     clear,
   output logic [cfg_slave_pkg::ADDR_W-1:0]                      reg_idx,
   input  logic [cfg_slave_pkg::DATA_W-1:0]                      reg_rdata
);

   cfg_slave_pkg::rd_state_e         state;
   logic [cfg_slave_pkg::ID_W-1:0]   cur_id;
   logic [cfg_slave_pkg::ID_W-1:0]   pick;
   logic [cfg_slave_pkg::ID_W-1:0]   sel_id;
   logic                             found;
   logic                             load_word;
   logic                             done;

   // lowest valid slot wins
   always_comb begin
      found = 1'b0;
      pick  = '0;
      for (int i = cfg_slave_pkg::NUM_IDS - 1; i >= 0; i--) begin
         if (slots[i].valid) begin
            found = 1'b1;
            pick  = cfg_slave_pkg::ID_W'(i);
         end
      end
   end

   assign sel_id    = (state == cfg_slave_pkg::RD_IDLE) ? pick : cur_id;
   assign reg_idx   = slots[sel_id].addr;   // slot addr already points at the next word
   assign load_word = (state == cfg_slave_pkg::RD_IDLE && found) ||
                      (state == cfg_slave_pkg::RD_BURST && r_ready && !r.last);
   assign done      = (state == cfg_slave_pkg::RD_BURST) && r_ready && r.last;

   always_comb begin
      advance         = '0;
      clear           = '0;
      advance[sel_id] = load_word;
      clear[cur_id]   = done;
   end

   //--------------------
   // FSM
   //--------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state  <= cfg_slave_pkg::RD_IDLE;
         cur_id <= '0;
      end else begin
         case (state)
            cfg_slave_pkg::RD_IDLE: begin
               if (found) begin
                  state  <= cfg_slave_pkg::RD_BURST;
                  cur_id <= pick;
               end
            end
            default: if (done) state <= cfg_slave_pkg::RD_IDLE;  // one idle cycle follows
         endcase
      end
   end

   assign r_valid = (state == cfg_slave_pkg::RD_BURST);

   always_ff @(posedge clk) begin
      if (load_word) begin
         r.id   <= sel_id;
         r.data <= reg_rdata;
         r.resp <= cfg_slave_pkg::RESP_OKAY;
         r.last <= (slots[sel_id].remaining == cfg_slave_pkg::CNT_W'(1));
      end
   end

   a_r_stable: assert property (@(posedge clk) disable iff (!reset_n)
      r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

//--- cfg_regfile.sv
//--------------------
// configuration register file, byte writable, combinational read
// reg 0 bit 0 drives the core reset, reg 1 holds the reset PC
//--------------------
module cfg_regfile (
   input  logic                              clk,
   input  logic                              reset_n,
   input  logic                              we,
   input  logic [cfg_slave_pkg::ADDR_W-1:0]  wr_idx,
   input  logic [cfg_slave_pkg::DATA_W-1:0]  wdata,
   input  logic [cfg_slave_pkg::STRB_W-1:0]  strb,
   input  logic [cfg_slave_pkg::ADDR_W-1:0]  rd_idx,
   output logic [cfg_slave_pkg::DATA_W-1:0]  rdata,
   output logic                              core_reset,
   output logic [cfg_slave_pkg::DATA_W-1:0]  reset_pc
);

   logic [cfg_slave_pkg::DATA_W-1:0] regs [cfg_slave_pkg::NUM_REGS];
   logic                             rst_aged;   // core reset already seen for one cycle
   logic                             ctrl_wr;

   assign ctrl_wr = we && (wr_idx == cfg_slave_pkg::ADDR_W'(cfg_slave_pkg::REG_CTRL)) && strb[0];

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         for (int i = 0; i < cfg_slave_pkg::NUM_REGS; i++) regs[i] <= '0;
         rst_aged <= 1'b0;
      end else begin
         if (we) begin
            for (int b = 0; b < cfg_slave_pkg::STRB_W; b++) begin
               if (strb[b]) regs[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
         end
         // self clear, core reset stays high for two cycles
         if (ctrl_wr) begin
            rst_aged <= 1'b0;
         end else if (regs[cfg_slave_pkg::REG_CTRL][0]) begin
            rst_aged <= !rst_aged;
            if (rst_aged) regs[cfg_slave_pkg::REG_CTRL][0] <= 1'b0;
         end
      end
   end

   assign rdata      = regs[rd_idx];
   assign core_reset = regs[cfg_slave_pkg::REG_CTRL][0];
   assign reset_pc   = regs[cfg_slave_pkg::REG_PC];

endmodule

//--- axi_cfg_slave.sv
//--------------------
// AXI config slave top level
// per-ID burst slots for writes and reads around a small register file
//--------------------
module axi_cfg_slave (
   input  logic                             clk,
   input  logic                             reset_n,
   input  cfg_slave_pkg::addr_req_t         aw,
   input  logic                             aw_valid,
   output logic                             aw_ready,
   input  cfg_slave_pkg::w_beat_t           w,
   input  logic                             w_valid,
   output logic                             w_ready,
   output cfg_slave_pkg::b_resp_t           b,
   output logic                             b_valid,
   input  logic                             b_ready,
   input  cfg_slave_pkg::addr_req_t         ar,
   input  logic                             ar_valid,
   output logic                             ar_ready,
   output cfg_slave_pkg::r_beat_t           r,
   output logic                             r_valid,
   input  logic                             r_ready,
   output logic                             core_reset,
   output logic [cfg_slave_pkg::DATA_W-1:0] reset_pc
);

   cfg_slave_pkg::slot_state_t [cfg_slave_pkg::NUM_IDS-1:0] wr_slots, rd_slots;
   logic [cfg_slave_pkg::NUM_IDS-1:0] wr_load, wr_adv, wr_clr;
   logic [cfg_slave_pkg::NUM_IDS-1:0] rd_load, rd_adv, rd_clr;
   cfg_slave_pkg::addr_req_t          wr_load_req, rd_load_req;
   logic                              reg_we;
   logic [cfg_slave_pkg::ADDR_W-1:0]  reg_wr_idx, reg_rd_idx;
   logic [cfg_slave_pkg::DATA_W-1:0]  reg_wdata, reg_rdata;
   logic [cfg_slave_pkg::STRB_W-1:0]  reg_strb;

   //--------------------
   // write side
   //--------------------
   addr_accept u_aw_accept (.clk, .reset_n, .req(aw), .req_valid(aw_valid),
      .req_ready(aw_ready), .slots(wr_slots), .load(wr_load), .load_req(wr_load_req));

   for (genvar i = 0; i < cfg_slave_pkg::NUM_IDS; i++) begin : g_wr_slot
      burst_slot u_slot (.clk, .reset_n, .load(wr_load[i]), .advance(wr_adv[i]),
         .clear(wr_clr[i]), .load_req(wr_load_req), .state(wr_slots[i]));
   end

   write_engine u_wr_engine (.clk, .reset_n, .w, .w_valid, .w_ready, .b, .b_valid,
      .b_ready, .slots(wr_slots), .advance(wr_adv), .clear(wr_clr), .reg_we,
      .reg_idx(reg_wr_idx), .reg_wdata, .reg_strb);

   //--------------------
   // read side
   //--------------------
   addr_accept u_ar_accept (.clk, .reset_n, .req(ar), .req_valid(ar_valid),
      .req_ready(ar_ready), .slots(rd_slots), .load(rd_load), .load_req(rd_load_req));

   for (genvar i = 0; i < cfg_slave_pkg::NUM_IDS; i++) begin : g_rd_slot
      burst_slot u_slot (.clk, .reset_n, .load(rd_load[i]), .advance(rd_adv[i]),
         .clear(rd_clr[i]), .load_req(rd_load_req), .state(rd_slots[i]));
   end

   read_engine u_rd_engine (.clk, .reset_n, .r, .r_valid, .r_ready, .slots(rd_slots),
      .advance(rd_adv), .clear(rd_clr), .reg_idx(reg_rd_idx), .reg_rdata);

   cfg_regfile u_regfile (.clk, .reset_n, .we(reg_we), .wr_idx(reg_wr_idx),
      .wdata(reg_wdata), .strb(reg_strb), .rd_idx(reg_rd_idx), .rdata(reg_rdata),
      .core_reset, .reset_pc);

endmodule

//--- tb_axi_cfg_slave.sv
//--------------------
// testbench for the AXI config slave
// drives aw/w/ar bursts, keeps a shadow copy of the register file and
// checks the DUT with concurrent assertions sampled on the falling edge
//--------------------
module tb_axi_cfg_slave;

   localparam int TIMEOUT = 40;   // cycles allowed per wait

   logic                                 clk = 1'b0;
   logic                                 reset_n;
   cfg_slave_pkg::addr_req_t             aw, ar;
   logic                                 aw_valid, aw_ready, ar_valid, ar_ready;
   cfg_slave_pkg::w_beat_t               w;
   logic                                 w_valid, w_ready;
   cfg_slave_pkg::b_resp_t               b, b_prev;
   logic                                 b_valid, b_ready;
   cfg_slave_pkg::r_beat_t               r, r_prev;
   logic                                 r_valid, r_ready;
   logic                                 core_reset;
   logic [cfg_slave_pkg::DATA_W-1:0]     reset_pc;

   logic [cfg_slave_pkg::DATA_W-1:0]     shadow [cfg_slave_pkg::NUM_REGS];
   logic [31:0]                          rng;
   logic [31:0]                          data;
   logic                                 quiet;   // reset plus the first cycle after it
   logic [3:0]                           exp_bid, exp_rid, exp_raddr;
   cfg_slave_pkg::axi_resp_e             exp_bresp;
   int                                   rd_left;
   int                                   cycle_count = 0;
   int                                   cr_start = -100;   // cycle of last core reset write
   int                                   check_errors = 0;
   int                                   timeouts = 0;

   axi_cfg_slave dut (.clk, .reset_n, .aw, .aw_valid, .aw_ready, .w, .w_valid, .w_ready,
      .b, .b_valid, .b_ready, .ar, .ar_valid, .ar_ready, .r, .r_valid, .r_ready,
      .core_reset, .reset_pc);

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      b_prev      <= b;   // payload of the cycle just ended
      r_prev      <= r;
   end

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
      check_errors++;
   endtask

   function automatic logic [31:0] next_rand();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   //--------------------
   // bus drivers
   //--------------------
   task automatic send_addr(input logic is_rd, input logic [3:0] id, input logic [3:0] addr,
                            input logic [3:0] len);
      int   n;
      logic ok;
      n = 0;
      if (is_rd) begin
         ar       = '{id: id, addr: addr, len: len};
         ar_valid = 1'b1;
      end else begin
         aw       = '{id: id, addr: addr, len: len};
         aw_valid = 1'b1;
      end
      do begin
         @(negedge clk);
         ok = is_rd ? ar_ready : aw_ready;
         n++;
      end while (!ok && n < TIMEOUT);
      if (!ok) begin
         $display("timeout: address for id %0d was never accepted", id);
         timeouts++;
      end
      @(posedge clk);
      #1;
      ar_valid = 1'b0;
      aw_valid = 1'b0;
   endtask

   task automatic send_beat(input logic [3:0] id, input logic [31:0] wdata,
                            input logic [3:0] strb, input logic last, input logic [3:0] idx);
      int   n;
      logic ok;
      n       = 0;
      w       = '{id: id, data: wdata, strb: strb, last: last};
      w_valid = 1'b1;
      do begin
         @(negedge clk);
         ok = w_ready;
         n++;
      end while (!ok && n < TIMEOUT);
      @(posedge clk);
      #1;
      w_valid = 1'b0;
      if (!ok) begin
         $display("timeout: write beat for id %0d was never accepted", id);
         timeouts++;
      end else begin
         for (int k = 0; k < 4; k++) begin
            if (strb[k]) shadow[idx][8*k +: 8] = wdata[8*k +: 8];
         end
         if (idx == 4'h0 && strb[0] && wdata[0]) cr_start = cycle_count;
         if (idx == 4'h0) shadow[0][0] = 1'b0;   // self clears before any read
      end
   endtask

   task automatic wait_b();
      int   n;
      logic ok;
      n = 0;
      do begin
         @(negedge clk);
         ok = b_valid && b_ready;
         n++;
      end while (!ok && n < TIMEOUT);
      if (!ok) begin
         $display("timeout: no write response arrived");
         timeouts++;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic write_burst(input logic [3:0] id, input logic [3:0] addr, input logic [3:0] len,
                              input int nbeats, input logic [3:0] strb,
                              input logic [31:0] set_bits, input cfg_slave_pkg::axi_resp_e resp);
      exp_bid   = id;
      exp_bresp = resp;
      send_addr(1'b0, id, addr, len);
      for (int i = 0; i < nbeats; i++) begin
         data = next_rand() | set_bits;
         send_beat(id, data, strb, i == nbeats - 1, 4'(addr + i));
      end
      wait_b();
   endtask

   task automatic read_burst(input logic [3:0] id, input logic [3:0] addr, input logic [3:0] len,
                             input logic random_ready);
      logic [31:0] rnd;
      int          n;
      logic        ok;
      exp_rid   = id;
      exp_raddr = addr;
      rd_left   = int'(len) + 1;
      send_addr(1'b1, id, addr, len);
      while (rd_left > 0) begin
         n = 0;
         do begin
            @(negedge clk);
            ok = r_valid && r_ready;
            @(posedge clk);
            #1;
            rnd     = next_rand();
            r_ready = !random_ready || rnd[16];
            n++;
         end while (!ok && n < TIMEOUT);
         if (!ok) begin
            $display("timeout: read beat for id %0d never completed", id);
            timeouts++;
            rd_left = 0;
         end else begin
            exp_raddr = exp_raddr + 4'd1;
            rd_left--;
         end
      end
      r_ready = 1'b1;
   endtask

   //--------------------
   // checks
   //--------------------
   a_rst: assert property (@(negedge clk)
      quiet |-> {aw_ready, ar_ready, b_valid, r_valid, w_ready, core_reset, reset_pc} == '0)
      else report_mismatch(
         "reset {aw_ready,ar_ready,b_valid,r_valid,w_ready,core_reset,reset_pc}",
         64'({aw_ready, ar_ready, b_valid, r_valid, w_ready, core_reset, reset_pc}), 64'(0));

   a_b: assert property (@(negedge clk) disable iff (!reset_n)
      b_valid |-> {b.id, b.resp} == {exp_bid, exp_bresp})
      else report_mismatch("{bid,bresp}", 64'({b.id, b.resp}), 64'({exp_bid, exp_bresp}));

   a_b_hold: assert property (@(negedge clk) disable iff (!reset_n)
      b_valid && !b_ready |=> b_valid && b == b_prev)
      else report_mismatch("held b payload", 64'(b), 64'(b_prev));

   a_w_block: assert property (@(negedge clk) disable iff (!reset_n)
      b_valid |-> !w_ready)
      else report_mismatch("w_ready while bvalid", 64'(w_ready), 64'(0));

   a_r_expected: assert property (@(negedge clk) disable iff (!reset_n)
      r_valid |-> rd_left > 0)
      else begin
         $display("read data appeared at t=%0t with no read outstanding", $time);
         check_errors++;
      end

   a_rdata: assert property (@(negedge clk) disable iff (!reset_n)
      r_valid && r_ready |-> r.data == shadow[exp_raddr])
      else report_mismatch("rdata", 64'(r.data), 64'(shadow[exp_raddr]));

   a_rid: assert property (@(negedge clk) disable iff (!reset_n)
      r_valid && r_ready |-> {r.id, r.resp} == {exp_rid, cfg_slave_pkg::RESP_OKAY})
      else report_mismatch("{rid,rresp}", 64'({r.id, r.resp}),
         64'({exp_rid, cfg_slave_pkg::RESP_OKAY}));

   a_rlast: assert property (@(negedge clk) disable iff (!reset_n)
      r_valid && r_ready |-> r.last == (rd_left == 1))
      else report_mismatch("rlast", 64'(r.last), 64'(rd_left == 1));

   a_r_hold: assert property (@(negedge clk) disable iff (!reset_n)
      r_valid && !r_ready |=> r_valid && r == r_prev)
      else report_mismatch("held r payload", 64'(r), 64'(r_prev));

   a_pc: assert property (@(negedge clk) reset_pc == shadow[cfg_slave_pkg::REG_PC])
      else report_mismatch("reset_pc", 64'(reset_pc), 64'(shadow[cfg_slave_pkg::REG_PC]));

   // pulse lasts the write cycle plus one
   a_core_reset: assert property (@(negedge clk) disable iff (!reset_n)
      core_reset == ((cycle_count - cr_start) < 2))
      else report_mismatch("core_reset", 64'(core_reset), 64'((cycle_count - cr_start) < 2));

   //--------------------
   // stimulus
   //--------------------
   initial begin
      reset_n   = 1'b0;
      quiet     = 1'b1;
      rng       = 32'h281f_6f97;
      aw        = '0;
      aw_valid  = 1'b0;
      w         = '0;
      w_valid   = 1'b0;
      b_ready   = 1'b1;
      ar        = '0;
      ar_valid  = 1'b0;
      r_ready   = 1'b1;
      exp_bid   = '0;
      exp_rid   = '0;
      exp_raddr = '0;
      exp_bresp = cfg_slave_pkg::RESP_OKAY;
      rd_left   = 0;
      data      = '0;
      for (int i = 0; i < cfg_slave_pkg::NUM_REGS; i++) shadow[i] = '0;
      repeat (10) @(posedge clk);
      #1 reset_n = 1'b1;
      @(posedge clk);
      #1 quiet = 1'b0;

      write_burst(4'h3, 4'h2, 4'h0, 1, 4'hf, '0, cfg_slave_pkg::RESP_OKAY);
      read_burst(4'h5, 4'h2, 4'h0, 1'b0);
      write_burst(4'h7, 4'h6, 4'h3, 4, 4'b0110, '0, cfg_slave_pkg::RESP_OKAY);
      read_burst(4'h9, 4'h6, 4'h3, 1'b1);   // random rready
      write_burst(4'h2, 4'h8, 4'h3, 2, 4'hf, '0, cfg_slave_pkg::RESP_SLVERR);  // wlast early
      read_burst(4'h2, 4'h8, 4'h3, 1'b1);
      write_burst(4'h1, 4'h0, 4'h0, 1, 4'h1, 32'h1, cfg_slave_pkg::RESP_OKAY);
      write_burst(4'h1, 4'h1, 4'h0, 1, 4'hf, '0, cfg_slave_pkg::RESP_OKAY);

      // response held off while the next beat waits
      b_ready   = 1'b0;
      exp_bid   = 4'h4;
      exp_bresp = cfg_slave_pkg::RESP_OKAY;
      send_addr(1'b0, 4'h4, 4'hc, 4'h0);
      send_beat(4'h4, next_rand(), 4'hf, 1'b1, 4'hc);
      send_addr(1'b0, 4'h5, 4'hd, 4'h0);
      data    = next_rand();
      w       = '{id: 4'h5, data: data, strb: 4'hf, last: 1'b1};
      w_valid = 1'b1;
      repeat (6) @(posedge clk);
      #1 b_ready = 1'b1;
      wait_b();
      exp_bid = 4'h5;
      send_beat(4'h5, data, 4'hf, 1'b1, 4'hd);
      wait_b();
      read_burst(4'h6, 4'hc, 4'h1, 1'b1);

      $display("errors: %0d check failures, %0d timeouts", check_errors, timeouts);
      if (check_errors + timeouts == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- axi_cfg_slave.f
cfg_slave_pkg.sv
addr_accept.sv
burst_slot.sv
write_engine.sv
read_engine.sv
cfg_regfile.sv
axi_cfg_slave.sv
tb_axi_cfg_slave.sv

//--- Makefile
SHELL     := /bin/bash
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       := tb_axi_cfg_slave
RTL_TOP   := axi_cfg_slave
FILELIST  := axi_cfg_slave.f
BUILD     := obj_dir
LOG       := sim.log
FAIL_MSG  := Checks failed

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BUILD)/V$(TOP)
	set -o pipefail; ./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
